/* src/fp_pkg.sv */
package fp_pkg;

    // IEEE-754 field widths and biases
    localparam int SP_EXP_W  = 8;
    localparam int SP_MANT_W = 23;
    localparam int SP_BIAS   = 127;
    localparam int HP_EXP_W  = 5;
    localparam int HP_MANT_W = 10;
    localparam int HP_BIAS   = 15;

    // Common internal format
    localparam int EXP_W = 10;             // Signed, unbiased
    localparam int SIG_W = SP_MANT_W + 1;  // With hidden bit
    localparam int ADD_W = SIG_W + 3;      // Guard, round and sticky below the significand

    localparam int OP_W = 3;
    localparam logic [OP_W-1:0] OP_ADD = 3'b000;
    localparam logic [OP_W-1:0] OP_SUB = 3'b001;
    localparam logic [OP_W-1:0] OP_MUL = 3'b010;

    localparam logic [31:0] QNAN_SP = 32'h7fc0_0000;
    localparam logic [15:0] QNAN_HP = 16'h7e00;

    // Busy cycles before the result register loads
    localparam logic [1:0] ADD_WAIT = 2'd2;
    localparam logic [1:0] MUL_WAIT = 2'd3;

    typedef union packed {
        struct packed {
            logic                 sign;
            logic [SP_EXP_W-1:0]  exp;
            logic [SP_MANT_W-1:0] mant;
        } sp;
        struct packed {
            logic [15:0]          pad;   // Zero in a half result
            logic                 sign;
            logic [HP_EXP_W-1:0]  exp;
            logic [HP_MANT_W-1:0] mant;
        } hp;
    } fp_word_u;

    typedef struct packed {
        logic is_zero;   // Also set for a flushed subnormal
        logic is_inf;
        logic is_nan;
    } fp_class_t;

    typedef struct packed {
        logic                    sign;
        logic signed [EXP_W-1:0] exp;   // Unbiased, single-precision range
        logic [SIG_W-1:0]        sig;   // Hidden bit at the top
        fp_class_t               cls;
    } fp_unpacked_t;

    // Execute result before rounding and packing
    typedef struct packed {
        logic                    sign;
        logic signed [EXP_W-1:0] exp;
        logic [SIG_W-1:0]        sig;
        logic                    sticky;  // Nonzero bits already dropped
        logic                    zero;
    } fp_raw_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

endpackage

/* src/fp_unpack.sv */
`timescale 1ns/100ps

module fp_unpack import fp_pkg::*; (
    input  fp_word_u     word,
    input  logic         mode_fp,
    output fp_unpacked_t value
);

    logic                    sign;
    logic [SP_EXP_W-1:0]     exp_field;
    logic [SP_MANT_W-1:0]    mant_field;
    logic                    exp_max;
    logic                    exp_min;
    logic signed [EXP_W-1:0] bias;

    // Select the view and move half fields to single-precision positions
    always_comb begin
        if (mode_fp) begin
            sign       = word.sp.sign;
            exp_field  = word.sp.exp;
            mant_field = word.sp.mant;
            exp_max    = &word.sp.exp;
            bias       = EXP_W'(SP_BIAS);
        end else begin
            sign       = word.hp.sign;
            exp_field  = SP_EXP_W'(word.hp.exp);
            mant_field = {word.hp.mant, {(SP_MANT_W - HP_MANT_W){1'b0}}};  // Left-aligned
            exp_max    = &word.hp.exp;
            bias       = EXP_W'(HP_BIAS);
        end
        exp_min = (exp_field == '0);
    end

    always_comb begin
        value.sign        = sign;
        value.exp         = $signed(EXP_W'(exp_field)) - bias;
        value.cls.is_zero = exp_min;                          // Subnormal flushes to zero
        value.cls.is_inf  = exp_max && (mant_field == '0);
        value.cls.is_nan  = exp_max && (mant_field != '0);

        // No significand for zero, Inf or NaN
        if (exp_min || exp_max) begin
            value.sig = '0;
        end else begin
            value.sig = {1'b1, mant_field};
        end
    end

endmodule

/* src/fp_add.sv */
`timescale 1ns/100ps

module fp_add import fp_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  fp_unpacked_t a,
    input  fp_unpacked_t b,
    input  logic         subtract,
    output fp_raw_t      sum
);

    fp_unpacked_t            big;
    fp_unpacked_t            small_op;
    logic                    b_sign;
    logic                    big_sign;
    logic                    a_first;
    logic                    eff_sub;
    logic signed [EXP_W-1:0] diff;
    logic [4:0]              shamt;
    logic [ADD_W+31:0]       shifted;
    logic [ADD_W-1:0]        big_ext;
    logic [ADD_W-1:0]        small_ext;
    logic                    align_sticky;
    logic [ADD_W:0]          total;
    logic [ADD_W-1:0]        norm;
    logic [4:0]              lz;
    fp_raw_t                 sum_d;

    // Order by magnitude with the effective sign carried by b
    always_comb begin
        b_sign   = b.sign ^ subtract;
        eff_sub  = a.sign ^ b_sign;
        a_first  = (a.exp > b.exp) || ((a.exp == b.exp) && (a.sig >= b.sig));
        big      = a_first ? a : b;
        small_op = a_first ? b : a;
        big_sign = a_first ? a.sign : b_sign;
    end

    // Shifts past 31 positions only reach sticky
    always_comb begin
        diff         = big.exp - small_op.exp;
        shamt        = (diff > 31) ? 5'd31 : diff[4:0];
        shifted      = {small_op.sig, 3'b000, 32'b0} >> shamt;
        small_ext    = shifted[ADD_W+31:32];
        align_sticky = |shifted[31:0];
        big_ext      = {big.sig, 3'b000};
    end

    always_comb begin
        if (eff_sub) begin
            total = {1'b0, big_ext} - {1'b0, small_ext[ADD_W-1:1], small_ext[0] | align_sticky};
        end else begin
            total = {1'b0, big_ext} + {1'b0, small_ext[ADD_W-1:1], small_ext[0] | align_sticky};
        end
    end

    // Leading zeros below the carry position
    always_comb begin
        lz = '0;
        for (int i = 0; i < ADD_W; i++) begin
            if (total[i]) begin
                lz = 5'(ADD_W - 1 - i);
            end
        end
        norm = total[ADD_W-1:0] << lz;
    end

    always_comb begin
        sum_d      = '0;
        sum_d.sign = big_sign;
        if (total[ADD_W]) begin  // Carry out needs one step right
            sum_d.sig    = total[ADD_W -: SIG_W];
            sum_d.exp    = big.exp + EXP_W'(1);
            sum_d.sticky = align_sticky | (|total[3:0]);
        end else begin
            sum_d.sig    = norm[ADD_W-1 -: SIG_W];
            sum_d.exp    = big.exp - EXP_W'(lz);
            sum_d.sticky = align_sticky | (|norm[2:0]);
        end

        if (a.cls.is_zero && b.cls.is_zero) begin
            sum_d.zero = 1'b1;
            sum_d.sign = a.sign & b_sign;   // Negative only for -0 + -0
        end else if (total == '0) begin
            sum_d.zero = 1'b1;              // Exact cancellation
            sum_d.sign = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum <= '0;
        end else begin
            sum <= sum_d;
        end
    end

endmodule

/* src/fp_mul.sv */
`timescale 1ns/100ps

module fp_mul import fp_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  fp_unpacked_t a,
    input  fp_unpacked_t b,
    output fp_raw_t      product
);

    logic [2*SIG_W-1:0]      prod_q;
    logic signed [EXP_W-1:0] exp_q;
    logic                    sign_q;
    fp_raw_t                 prod_d;

    // Stage one registers the full significand product and exponent sum
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_q <= '0;
            exp_q  <= '0;
            sign_q <= 1'b0;
        end else begin
            prod_q <= a.sig * b.sig;
            exp_q  <= a.exp + b.exp;
            sign_q <= a.sign ^ b.sign;
        end
    end

    // Product of two 1.x values is below 4, so one step at most
    always_comb begin
        prod_d      = '0;
        prod_d.sign = sign_q;
        prod_d.zero = (prod_q == '0);
        if (prod_q[2*SIG_W-1]) begin
            prod_d.sig    = prod_q[2*SIG_W-1 -: SIG_W];
            prod_d.exp    = exp_q + EXP_W'(1);
            prod_d.sticky = |prod_q[SIG_W-1:0];
        end else begin
            prod_d.sig    = prod_q[2*SIG_W-2 -: SIG_W];
            prod_d.exp    = exp_q;
            prod_d.sticky = |prod_q[SIG_W-2:0];
        end
    end

    // Stage two
    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
        end else begin
            product <= prod_d;
        end
    end

endmodule

/* src/fp_pack.sv */
`timescale 1ns/100ps

module fp_pack import fp_pkg::*; (
    input  fp_raw_t         raw,
    input  fp_unpacked_t    a,
    input  fp_unpacked_t    b,
    input  logic [OP_W-1:0] op_code,
    input  logic            mode_fp,
    output fp_word_u        word,
    output fp_flags_t       flags
);

    logic                  is_mul;
    logic                  b_sign;
    logic                  out_nan;
    logic                  out_inf;
    logic                  out_zero;
    logic                  out_sign;
    logic signed [EXP_W:0] bias_t;
    logic signed [EXP_W:0] exp_top;
    logic signed [EXP_W:0] biased;
    logic                  cut_bits;

    always_comb begin
        is_mul = (op_code == OP_MUL);
        b_sign = b.sign ^ (op_code == OP_SUB);

        // Half also drops the low 13 significand bits
        if (mode_fp) begin
            bias_t   = (EXP_W+1)'(SP_BIAS);
            exp_top  = (EXP_W+1)'((1 << SP_EXP_W) - 2);
            cut_bits = 1'b0;
        end else begin
            bias_t   = (EXP_W+1)'(HP_BIAS);
            exp_top  = (EXP_W+1)'((1 << HP_EXP_W) - 2);
            cut_bits = |raw.sig[SP_MANT_W-HP_MANT_W-1:0];
        end
        biased = raw.exp + bias_t;

        out_nan  = 1'b0;
        out_inf  = 1'b0;
        out_zero = 1'b0;
        out_sign = raw.sign;
        flags    = '0;

        if (a.cls.is_nan || b.cls.is_nan) begin
            out_nan       = 1'b1;
            flags.invalid = 1'b1;
        end else if (is_mul) begin
            out_sign = a.sign ^ b.sign;
            if ((a.cls.is_inf && b.cls.is_zero) || (a.cls.is_zero && b.cls.is_inf)) begin
                out_nan       = 1'b1;
                flags.invalid = 1'b1;
            end else if (a.cls.is_inf || b.cls.is_inf) begin
                out_inf = 1'b1;
            end else if (a.cls.is_zero || b.cls.is_zero) begin
                out_zero = 1'b1;
            end
        end else if (a.cls.is_inf && b.cls.is_inf && (a.sign != b_sign)) begin
            out_nan       = 1'b1;   // Inf - Inf
            flags.invalid = 1'b1;
        end else if (a.cls.is_inf || b.cls.is_inf) begin
            out_inf  = 1'b1;
            out_sign = a.cls.is_inf ? a.sign : b_sign;
        end

        // Range check and truncation of a finite result
        if (!(out_nan || out_inf || out_zero)) begin
            if (raw.zero) begin
                out_zero = 1'b1;
            end else if (biased > exp_top) begin
                out_inf        = 1'b1;
                flags.overflow = 1'b1;
                flags.inexact  = 1'b1;
            end else if (biased < 1) begin
                out_zero        = 1'b1;
                flags.underflow = 1'b1;
                flags.inexact   = 1'b1;
            end else begin
                flags.inexact = raw.sticky | cut_bits;
            end
        end

        word = '0;
        if (out_nan) begin
            word = mode_fp ? QNAN_SP : {16'h0000, QNAN_HP};
        end else if (mode_fp) begin
            word.sp.sign = out_sign;
            if (out_inf) begin
                word.sp.exp = '1;
            end else if (!out_zero) begin
                word.sp.exp  = biased[SP_EXP_W-1:0];
                word.sp.mant = raw.sig[SP_MANT_W-1:0];    // Hidden bit dropped
            end
        end else begin
            word.hp.sign = out_sign;
            if (out_inf) begin
                word.hp.exp = '1;
            end else if (!out_zero) begin
                word.hp.exp  = biased[HP_EXP_W-1:0];
                word.hp.mant = raw.sig[SP_MANT_W-1 -: HP_MANT_W];
            end
        end
    end

endmodule

/* src/fp_alu.sv */
`timescale 1ns/100ps

module fp_alu import fp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic [31:0]     op_a,
    input  logic [31:0]     op_b,
    input  logic [OP_W-1:0] op_code,
    input  logic            mode_fp,     // 1 selects single precision
    output logic            ready,
    output logic            valid_out,
    output fp_word_u        result,
    output fp_flags_t       flags
);

    fp_word_u        cap_a;
    fp_word_u        cap_b;
    logic [OP_W-1:0] cap_op;
    logic            cap_mode;
    logic            accept;
    logic [1:0]      wait_cnt;
    fp_unpacked_t    val_a;
    fp_unpacked_t    val_b;
    fp_raw_t         add_sum;
    fp_raw_t         mul_prod;
    fp_raw_t         raw_sel;
    fp_word_u        pack_word;
    fp_flags_t       pack_flags;

    assign accept = start && ready;

    // Operands stay put while busy
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_a    <= op_a;
            cap_b    <= op_b;
            cap_op   <= op_code;
            cap_mode <= mode_fp;
        end
    end

    fp_unpack u_unpack_a (.word(cap_a), .mode_fp(cap_mode), .value(val_a));
    fp_unpack u_unpack_b (.word(cap_b), .mode_fp(cap_mode), .value(val_b));

    fp_add u_add (
        .clk     (clk),
        .rst     (rst),
        .a       (val_a),
        .b       (val_b),
        .subtract(cap_op == OP_SUB),
        .sum     (add_sum)
    );

    fp_mul u_mul (
        .clk    (clk),
        .rst    (rst),
        .a      (val_a),
        .b      (val_b),
        .product(mul_prod)
    );

    assign raw_sel = (cap_op == OP_MUL) ? mul_prod : add_sum;  // Unknown codes add

    fp_pack u_pack (
        .raw    (raw_sel),
        .a      (val_a),
        .b      (val_b),
        .op_code(cap_op),
        .mode_fp(cap_mode),
        .word   (pack_word),
        .flags  (pack_flags)
    );

    // Idle while ready is high, otherwise count down to the result load
    always_ff @(posedge clk) begin
        if (rst) begin
            ready     <= 1'b1;
            valid_out <= 1'b0;
            wait_cnt  <= '0;
            result    <= '0;
            flags     <= '0;
        end else begin
            valid_out <= 1'b0;
            if (ready) begin
                if (start) begin
                    ready    <= 1'b0;
                    wait_cnt <= (op_code == OP_MUL) ? MUL_WAIT : ADD_WAIT;
                end
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                ready     <= 1'b1;
                valid_out <= 1'b1;
                result    <= pack_word;
                flags     <= pack_flags;
            end
        end
    end

endmodule

/* sim/fp_ref.svh */
`ifndef FP_REF_SVH
`define FP_REF_SVH

// Splits a word into sign, unbiased exponent, significand and class {zero, inf, nan}
function automatic void decode_operand(input logic [31:0] w, input logic sp,
                                       output logic sign, output int exp,
                                       output logic [127:0] sig, output logic [2:0] cls);
    int field;
    int mant;
    int top;
    int frac_w;
    frac_w = sp ? 23 : 10;
    top    = sp ? 255 : 31;
    sign   = sp ? w[31] : w[15];
    field  = sp ? int'(w[30:23]) : int'(w[14:10]);
    mant   = sp ? int'(w[22:0]) : int'(w[9:0]);
    exp    = field - (sp ? 127 : 15);
    cls    = {field == 0, (field == top) && (mant == 0), (field == top) && (mant != 0)};
    // Subnormals read as zero
    if (field == 0 || field == top) begin
        sig = '0;
    end else begin
        sig = 128'((1 << frac_w) | mant);
    end
endfunction

function automatic logic [31:0] make_word(input logic sign, input int field,
                                          input logic [127:0] mant, input logic sp);
    if (sp) begin
        return {sign, 8'(field), mant[22:0]};
    end
    return {16'h0000, sign, 5'(field), mant[9:0]};  // Upper half stays zero
endfunction

// Truncates an exact magnitude mag * 2^lsb_exp and checks the format range
function automatic logic [35:0] round_and_pack(input logic sign, input logic [127:0] mag,
                                               input int lsb_exp, input logic sp);
    int           frac_w;
    int           top;
    int           msb;
    int           biased;
    logic [127:0] mant;
    logic         lost;
    frac_w = sp ? 23 : 10;
    top    = sp ? 255 : 31;
    msb    = 0;
    for (int i = 0; i < 128; i++) begin
        if (mag[i])
            msb = i;
    end
    biased = lsb_exp + msb + (sp ? 127 : 15);
    if (msb > frac_w) begin
        mant = mag >> (msb - frac_w);
        lost = (mant << (msb - frac_w)) != mag;
    end else begin
        mant = mag << (frac_w - msb);
        lost = 1'b0;
    end
    if (biased >= top) begin
        return {make_word(sign, top, 128'd0, sp), 4'b0101};
    end
    if (biased < 1) begin
        return {make_word(sign, 0, 128'd0, sp), 4'b0011};
    end
    return {make_word(sign, biased, mant, sp), 3'b000, lost};
endfunction

// Expected {word, invalid, overflow, underflow, inexact}
function automatic logic [35:0] expected_result(input logic [31:0] a_word,
                                                input logic [31:0] b_word,
                                                input logic [2:0] op, input logic sp);
    logic         sa;
    logic         sb;
    logic         sbig;
    logic         ssmall;
    int           ea;
    int           eb;
    int           ebig;
    int           esmall;
    int           frac_w;
    int           top;
    logic [127:0] ma;
    logic [127:0] mb;
    logic [127:0] mbig;
    logic [127:0] msmall;
    logic [127:0] aligned;
    logic [127:0] wide;
    logic [2:0]   ca;
    logic [2:0]   cb;
    logic [31:0]  qnan;
    frac_w = sp ? 23 : 10;
    top    = sp ? 255 : 31;
    qnan   = sp ? 32'h7fc0_0000 : 32'h0000_7e00;
    decode_operand(a_word, sp, sa, ea, ma, ca);
    decode_operand(b_word, sp, sb, eb, mb, cb);
    if (ca[0] || cb[0]) begin
        return {qnan, 4'b1000};
    end
    if (op == OP_MUL) begin
        sbig = sa ^ sb;
        if ((ca[1] && cb[2]) || (ca[2] && cb[1])) begin
            return {qnan, 4'b1000};
        end
        if (ca[1] || cb[1]) begin
            return {make_word(sbig, top, 128'd0, sp), 4'b0000};
        end
        if (ca[2] || cb[2]) begin
            return {make_word(sbig, 0, 128'd0, sp), 4'b0000};
        end
        return round_and_pack(sbig, ma * mb, ea + eb - 2 * frac_w, sp);
    end
    sb = sb ^ (op == OP_SUB);   // Effective sign of b
    if (ca[1] && cb[1] && (sa != sb)) begin
        return {qnan, 4'b1000};
    end
    if (ca[1] || cb[1]) begin
        return {make_word(ca[1] ? sa : sb, top, 128'd0, sp), 4'b0000};
    end
    if (ca[2] && cb[2]) begin
        return {make_word(sa & sb, 0, 128'd0, sp), 4'b0000};
    end
    // A zero always counts as the smaller magnitude
    if (cb[2] || (!ca[2] && (ea > eb || (ea == eb && ma >= mb)))) begin
        sbig   = sa;
        ebig   = ea;
        mbig   = ma;
        ssmall = sb;
        esmall = eb;
        msmall = mb;
    end else begin
        sbig   = sb;
        ebig   = eb;
        mbig   = mb;
        ssmall = sa;
        esmall = ea;
        msmall = ma;
    end
    // Lost alignment bits are jammed into the LSB of 64 extra bits
    aligned = (msmall << 64) >> (ebig - esmall);
    if ((aligned << (ebig - esmall)) != (msmall << 64))
        aligned[0] = 1'b1;
    wide = mbig << 64;
    wide = (sbig == ssmall) ? wide + aligned : wide - aligned;
    if (wide == '0) begin
        return {make_word(1'b0, 0, 128'd0, sp), 4'b0000};
    end
    return round_and_pack(sbig, wide, ebig - frac_w - 64, sp);
endfunction

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

`endif

/* sim/fp_alu_tb.sv */
`timescale 1ns/100ps

module fp_alu_tb import fp_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 48;   // Upper bound

    logic            clk;
    logic            rst;
    logic            start;
    logic [31:0]     op_a;
    logic [31:0]     op_b;
    logic [OP_W-1:0] op_code;
    logic            mode_fp;
    logic            ready;
    logic            valid_out;
    logic [31:0]     result;
    logic [3:0]      flags;

    logic [31:0] lfsr;
    int          cycle;
    int          value_errors;
    int          protocol_errors;
    string       name_q[$];
    logic [35:0] expect_q[$];
    int          due_q[$];

    `include "fp_ref.svh"

    fp_alu UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    // Called on a falling edge, returns one falling edge after acceptance
    task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
                          input logic [OP_W-1:0] op, input logic sp);
        while (!ready) begin
            @(negedge clk);
        end
        start   = 1'b1;
        op_a    = a;
        op_b    = b;
        op_code = op;
        mode_fp = sp;
        name_q.push_back(name);
        expect_q.push_back(expected_result(a, b, op, sp));
        due_q.push_back(cycle + 1 + ((op == OP_MUL) ? 4 : 3));
        @(negedge clk);
        start = 1'b0;
        if (ready) begin
            $display("ready stayed high after %s was accepted", name);
            protocol_errors++;
        end
    endtask

    task automatic ignored_start;
        run_op("start while busy", 32'h4040_0000, 32'h3fc0_0000, OP_MUL, 1'b1);
        start   = 1'b1;   // The DUT is busy and must drop this
        op_a    = 32'h7f80_0000;
        op_b    = 32'h0000_0000;
        op_code = OP_ADD;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic report_counts;
        $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    endtask

    initial begin : compare
        logic [35:0] exp_r;
        string       name;
        int          due;
        forever begin
            @(negedge clk);
            if (valid_out) begin
                if (expect_q.size() == 0) begin
                    $display("valid_out pulsed with no operation pending");
                    protocol_errors++;
                end else begin
                    exp_r = expect_q.pop_front();
                    name  = name_q.pop_front();
                    due   = due_q.pop_front();
                    if ({result, flags} != exp_r) begin
                        $display("FAIL %s: expected %h/%b, got %h/%b",
                                 name, exp_r[35:4], exp_r[3:0], result, flags);
                        value_errors++;
                    end
                    if (cycle != due) begin
                        $display("%s: valid_out came in cycle %0d instead of %0d",
                                 name, cycle, due);
                        protocol_errors++;
                    end
                    if (!ready) begin
                        $display("%s: ready was low during valid_out", name);
                        protocol_errors++;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sel;
        rst     = 1'b1;
        start   = 1'b0;
        op_a    = '0;
        op_b    = '0;
        op_code = OP_ADD;
        mode_fp = 1'b1;
        lfsr    = 32'h33ec;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!ready || valid_out || result != '0 || flags != '0) begin
            $display("Outputs were not idle after reset");
            protocol_errors++;
        end

        run_op("sp add", 32'h3fc0_0000, 32'h4010_0000, OP_ADD, 1'b1);
        run_op("sp sub", 32'h40e0_0000, 32'h3ec0_0000, OP_SUB, 1'b1);
        run_op("sp cancel", 32'h3f80_0000, 32'h3f80_0000, OP_SUB, 1'b1);
        run_op("sp add cancel", 32'hc020_0000, 32'h4020_0000, OP_ADD, 1'b1);
        run_op("sp add tiny", 32'h3f80_0000, 32'h3080_0000, OP_ADD, 1'b1);
        run_op("sp sub tiny", 32'h3f80_0000, 32'h3080_0000, OP_SUB, 1'b1);
        run_op("sp mul", 32'h4040_0000, 32'hbf00_0000, OP_MUL, 1'b1);
        run_op("sp mul inexact", 32'h3dcc_cccd, 32'h3dcc_cccd, OP_MUL, 1'b1);
        run_op("sp unused code", 32'h3f80_0000, 32'h4000_0000, 3'b101, 1'b1);
        run_op("hp add", 32'h0000_3e00, 32'h0000_4080, OP_ADD, 1'b0);
        run_op("hp sub", 32'h0000_4700, 32'h0000_3600, OP_SUB, 1'b0);
        run_op("hp cancel", 32'h0000_3c00, 32'h0000_3c00, OP_SUB, 1'b0);
        run_op("hp mul", 32'h0000_4200, 32'h0000_b800, OP_MUL, 1'b0);
        run_op("hp mul inexact", 32'h0000_2e66, 32'h0000_2e66, OP_MUL, 1'b0);
        run_op("hp sub tiny", 32'h0000_3c00, 32'h0000_1000, OP_SUB, 1'b0);
        run_op("hp upper bits", 32'hdead_3c00, 32'hbeef_4000, OP_ADD, 1'b0);

        run_op("sp nan", 32'h7f80_0001, 32'h3f80_0000, OP_ADD, 1'b1);
        run_op("hp nan", 32'h0000_7c01, 32'h0000_3c00, OP_MUL, 1'b0);
        run_op("sp inf minus inf", 32'h7f80_0000, 32'h7f80_0000, OP_SUB, 1'b1);
        run_op("hp inf plus -inf", 32'h0000_7c00, 32'h0000_fc00, OP_ADD, 1'b0);
        run_op("sp zero times inf", 32'h0000_0000, 32'hff80_0000, OP_MUL, 1'b1);
        run_op("hp zero times inf", 32'h0000_8000, 32'h0000_7c00, OP_MUL, 1'b0);
        run_op("sp inf plus one", 32'hff80_0000, 32'h3f80_0000, OP_ADD, 1'b1);
        run_op("sp inf times -2", 32'h7f80_0000, 32'hc000_0000, OP_MUL, 1'b1);
        run_op("hp one minus inf", 32'h0000_3c00, 32'h0000_7c00, OP_SUB, 1'b0);
        run_op("sp zero times -3", 32'h0000_0000, 32'hc040_0000, OP_MUL, 1'b1);
        run_op("hp -0 times 2", 32'h0000_8000, 32'h0000_4000, OP_MUL, 1'b0);
        run_op("sp -0 plus -0", 32'h8000_0000, 32'h8000_0000, OP_ADD, 1'b1);

        run_op("sp mul overflow", 32'h7f00_0000, 32'h4000_0000, OP_MUL, 1'b1);
        run_op("sp add overflow", 32'hff7f_ffff, 32'hff7f_ffff, OP_ADD, 1'b1);
        run_op("sp mul underflow", 32'h0080_0000, 32'h3f00_0000, OP_MUL, 1'b1);
        run_op("sp neg underflow", 32'h8080_0000, 32'h3f00_0000, OP_MUL, 1'b1);
        run_op("sp sub underflow", 32'h00c0_0000, 32'h0080_0000, OP_SUB, 1'b1);
        run_op("hp mul overflow", 32'h0000_7800, 32'h0000_4000, OP_MUL, 1'b0);
        run_op("hp add overflow", 32'h0000_7bff, 32'h0000_7bff, OP_ADD, 1'b0);
        run_op("hp neg underflow", 32'h0000_8400, 32'h0000_3800, OP_MUL, 1'b0);
        run_op("sp subnormal add", 32'h0000_0001, 32'h3f80_0000, OP_ADD, 1'b1);
        run_op("sp subnormal mul", 32'h0040_0000, 32'h4000_0000, OP_MUL, 1'b1);
        run_op("hp subnormal add", 32'h0000_0001, 32'h0000_3c00, OP_ADD, 1'b0);
        run_op("hp subnormal mul", 32'h0000_8200, 32'h0000_4000, OP_MUL, 1'b0);
        ignored_start();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_bits(32, a);
            random_bits(32, b);
            random_bits(4, sel);
            if (sel[0]) begin   // A shared exponent field makes cancellation likely
                if (sel[3])
                    b[30:23] = a[30:23];
                else
                    b[14:10] = a[14:10];
            end
            run_op($sformatf("random %0d", n), a, b, OP_W'(sel[2:1]), sel[3]);
        end

        for (int i = 0; i < 10 && expect_q.size() > 0; i++) begin
            @(negedge clk);
        end
        if (expect_q.size() > 0) begin
            $display("%0d results never arrived", expect_q.size());
            protocol_errors += expect_q.size();
        end
        report_counts();
        if (value_errors + protocol_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(CLK_PERIOD * ((NUM_DIRECTED + NUM_RANDOM) * 6 + 100));
        $display("Watchdog expired before all operations completed");
        report_counts();
        $display("Test FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+sim
src/fp_pkg.sv
src/fp_unpack.sv
src/fp_add.sv
src/fp_mul.sv
src/fp_pack.sv
src/fp_alu.sv
sim/fp_alu_tb.sv

/* Bender.yml */
package:
  name: fp_alu

sources:
  - src/fp_pkg.sv
  - src/fp_unpack.sv
  - src/fp_add.sv
  - src/fp_mul.sv
  - src/fp_pack.sv
  - src/fp_alu.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/fp_alu_tb.sv
